// File: hdl/ts_pkg.sv
`default_nettype none

package ts_pkg;

	localparam int pkt_bytes = 188;
	localparam int pkt_words = 47; // 188 / 4

	localparam logic [7:0] sync_byte = 8'h47;

	localparam int pid_width = 13;

	localparam int num_slots = 4;
	localparam int slot_width = 2;

	localparam int idx_width = 8; // holds 0..187

endpackage

`default_nettype wire

// File: hdl/wb_map_pkg.sv
`default_nettype none

package wb_map_pkg;

	localparam int adr_width = 9;

	localparam logic [adr_width-1:0] adr_ctrl = 9'h000; // bit 0 match_enable
	localparam logic [adr_width-1:0] adr_count = 9'h004;
	localparam logic [adr_width-1:0] adr_status = 9'h008; // bit 0 capture_valid
	localparam logic [adr_width-1:0] adr_pid_base = 9'h010; // 4 slots
	localparam logic [adr_width-1:0] adr_buf_base = 9'h100; // 47 words

	// one bus word, seen either raw or as the slot fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [14:0] pad1;
			logic enable;
			logic [2:0] pad0;
			logic [ts_pkg::pid_width-1:0] pid;
		} f;
	} pid_reg_u;

endpackage

`default_nettype wire

// File: hdl/ts_framer.sv
`timescale 1ns/1ps
`default_nettype none

module ts_framer (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [7:0] ts_data,
	input wire logic ts_valid,
	input wire logic ts_sync,
	output logic byte_valid,
	output logic [7:0] byte_data,
	output logic [ts_pkg::idx_width-1:0] byte_idx,
	output logic pkt_start,
	output logic pkt_end,
	output logic pkt_abort
);

	logic pkt_open;
	logic [ts_pkg::idx_width-1:0] next_idx;
	logic is_sync;

	assign is_sync = ts_sync && (ts_data == ts_pkg::sync_byte);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pkt_open <= 1'b0;
			next_idx <= '0;
			byte_valid <= 1'b0;
			pkt_start <= 1'b0;
			pkt_end <= 1'b0;
			pkt_abort <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			pkt_start <= 1'b0;
			pkt_end <= 1'b0;
			pkt_abort <= 1'b0;
			if (ts_valid) begin
				if (is_sync) begin
					pkt_abort <= pkt_open; // previous packet cut short
					pkt_open <= 1'b1;
					pkt_start <= 1'b1;
					byte_valid <= 1'b1;
					next_idx <= 8'd1;
				end else if (pkt_open) begin
					byte_valid <= 1'b1;
					next_idx <= next_idx + 8'd1;
					if (next_idx == 8'(ts_pkg::pkt_bytes - 1)) begin
						pkt_end <= 1'b1;
						pkt_open <= 1'b0;
					end
				end
			end
		end
	end

	// payload side, no reset
	always_ff @(posedge clk) begin
		if (ts_valid && (is_sync || pkt_open)) begin
			byte_data <= ts_data;
			byte_idx <= is_sync ? '0 : next_idx;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		byte_valid |-> byte_idx < ts_pkg::idx_width'(ts_pkg::pkt_bytes));

	assert property (@(posedge clk) disable iff (!rst_n)
		pkt_end |-> byte_valid && byte_idx == ts_pkg::idx_width'(ts_pkg::pkt_bytes - 1));

endmodule

`default_nettype wire

// File: hdl/pid_matcher.sv
`timescale 1ns/1ps
`default_nettype none

module pid_matcher (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic byte_valid,
	input wire logic [7:0] byte_data,
	input wire logic [ts_pkg::idx_width-1:0] byte_idx,
	input wire logic pid_we,
	input wire logic [ts_pkg::slot_width-1:0] pid_slot,
	input wire logic [31:0] pid_wdata,
	input wire logic [ts_pkg::slot_width-1:0] pid_rslot,
	output logic [31:0] pid_rdata,
	output logic hit_valid,
	output logic hit
);

	logic [ts_pkg::pid_width-1:0] slot_pid [ts_pkg::num_slots];
	logic slot_en [ts_pkg::num_slots];

	wb_map_pkg::pid_reg_u wr_reg;
	wb_map_pkg::pid_reg_u rd_reg;

	logic [4:0] hdr_hi; // low 5 bits of header byte 1
	logic [ts_pkg::pid_width-1:0] cur_pid;
	logic [ts_pkg::num_slots-1:0] slot_hit;

	assign wr_reg = pid_wdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < ts_pkg::num_slots; i++) begin
				slot_pid[i] <= '0;
				slot_en[i] <= 1'b0;
			end
		end else if (pid_we) begin
			slot_pid[pid_slot] <= wr_reg.f.pid;
			slot_en[pid_slot] <= wr_reg.f.enable;
		end
	end

	always_comb begin
		rd_reg.raw = '0; // padding reads as zero
		rd_reg.f.pid = slot_pid[pid_rslot];
		rd_reg.f.enable = slot_en[pid_rslot];
	end

	assign pid_rdata = rd_reg.raw;

	always_ff @(posedge clk) begin
		if (byte_valid && byte_idx == 8'd1)
			hdr_hi <= byte_data[4:0];
	end

	assign cur_pid = {hdr_hi, byte_data};

	always_comb begin
		for (int i = 0; i < ts_pkg::num_slots; i++)
			slot_hit[i] = slot_en[i] && (slot_pid[i] == cur_pid);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hit_valid <= 1'b0;
			hit <= 1'b0;
		end else begin
			hit_valid <= byte_valid && byte_idx == 8'd2;
			if (byte_valid && byte_idx == 8'd2)
				hit <= |slot_hit;
		end
	end

endmodule

`default_nettype wire

// File: hdl/packet_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module packet_buffer (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic byte_valid,
	input wire logic [7:0] byte_data,
	input wire logic [ts_pkg::idx_width-1:0] byte_idx,
	input wire logic commit,
	input wire logic [5:0] rd_word,
	output logic [31:0] rd_data
);

	logic [3:0][7:0] mem [2][ts_pkg::pkt_words];

	logic vis_bank; // bank the host sees
	logic wr_bank;
	logic [5:0] wr_word;
	logic [1:0] wr_lane;

	// byte 0 of the next packet can land in the same cycle as commit,
	// so it must already go to the bank that becomes staging
	assign wr_bank = ~vis_bank ^ commit;
	assign wr_word = byte_idx[7:2];
	assign wr_lane = byte_idx[1:0]; // little endian lanes

	always_ff @(posedge clk) begin
		if (!rst_n)
			vis_bank <= 1'b0;
		else if (commit)
			vis_bank <= ~vis_bank;
	end

	always_ff @(posedge clk) begin
		if (byte_valid)
			mem[wr_bank][wr_word][wr_lane] <= byte_data;
	end

	always_comb begin
		if (rd_word < 6'(ts_pkg::pkt_words))
			rd_data = mem[vis_bank][rd_word];
		else
			rd_data = '0;
	end

endmodule

`default_nettype wire

// File: hdl/capture_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic hit_valid,
	input wire logic hit,
	input wire logic pkt_start,
	input wire logic pkt_end,
	input wire logic match_enable,
	output logic commit,
	output logic [31:0] matched_count,
	output logic capture_valid
);

	logic hit_held;

	always_ff @(posedge clk) begin
		if (!rst_n)
			hit_held <= 1'b0;
		else if (pkt_start)
			hit_held <= 1'b0; // new packet, old decision void
		else if (hit_valid)
			hit_held <= hit;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			commit <= 1'b0;
			matched_count <= '0;
			capture_valid <= 1'b0;
		end else begin
			commit <= pkt_end && hit_held && match_enable;
			if (commit) begin
				matched_count <= matched_count + 32'd1;
				capture_valid <= 1'b1; // sticky
			end
		end
	end

	// hit still latched while its commit is out
	assert property (@(posedge clk) disable iff (!rst_n) commit |-> hit_held);

endmodule

`default_nettype wire

// File: hdl/wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_regs (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [wb_map_pkg::adr_width-1:0] wb_adr,
	input wire logic [31:0] wb_wdata,
	input wire logic [31:0] matched_count,
	input wire logic capture_valid,
	input wire logic [31:0] pid_rdata,
	input wire logic [31:0] rd_data,
	output logic [31:0] wb_rdata,
	output logic wb_ack,
	output logic match_enable,
	output logic pid_we,
	output logic [ts_pkg::slot_width-1:0] pid_slot,
	output logic [ts_pkg::slot_width-1:0] pid_rslot,
	output logic [5:0] rd_word
);

	logic req; // new access, acked at this edge
	logic is_pid;
	logic is_buf;
	logic [31:0] rd_mux;

	assign req = wb_cyc && wb_stb && !wb_ack;

	assign is_pid = wb_adr[8:4] == wb_map_pkg::adr_pid_base[8:4];
	assign is_buf = wb_adr[8] == wb_map_pkg::adr_buf_base[8] &&
		wb_adr[7:2] < 6'(ts_pkg::pkt_words);

	assign pid_slot = wb_adr[3:2];
	assign pid_rslot = wb_adr[3:2];
	assign rd_word = wb_adr[7:2];
	assign pid_we = req && wb_we && is_pid;

	always_comb begin
		if (wb_adr == wb_map_pkg::adr_ctrl)
			rd_mux = {31'd0, match_enable};
		else if (wb_adr == wb_map_pkg::adr_count)
			rd_mux = matched_count;
		else if (wb_adr == wb_map_pkg::adr_status)
			rd_mux = {31'd0, capture_valid};
		else if (is_pid)
			rd_mux = pid_rdata;
		else if (is_buf)
			rd_mux = rd_data;
		else
			rd_mux = '0; // unmapped
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			match_enable <= 1'b0;
		end else begin
			wb_ack <= req;
			if (req && wb_we && wb_adr == wb_map_pkg::adr_ctrl)
				match_enable <= wb_wdata[0];
		end
	end

	always_ff @(posedge clk) begin
		if (req)
			wb_rdata <= rd_mux;
	end

	// classic cycle, host holds the request steady until it sees ack
	assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we));

endmodule

`default_nettype wire

// File: hdl/ts_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module ts_monitor (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [7:0] ts_data,
	input wire logic ts_valid,
	input wire logic ts_sync,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [wb_map_pkg::adr_width-1:0] wb_adr,
	input wire logic [31:0] wb_wdata,
	output logic [31:0] wb_rdata,
	output logic wb_ack
);

	logic byte_valid;
	logic [7:0] byte_data;
	logic [ts_pkg::idx_width-1:0] byte_idx;
	logic pkt_start;
	logic pkt_end;
	logic pkt_abort; // only read by the check below
	logic hit_valid;
	logic hit;
	logic commit;
	logic [31:0] matched_count;
	logic capture_valid;
	logic match_enable;
	logic pid_we;
	logic [ts_pkg::slot_width-1:0] pid_slot;
	logic [ts_pkg::slot_width-1:0] pid_rslot;
	logic [31:0] pid_rdata;
	logic [5:0] rd_word;
	logic [31:0] rd_data;

	ts_framer ts_framer_i (.clk, .rst_n, .ts_data, .ts_valid, .ts_sync,
		.byte_valid, .byte_data, .byte_idx, .pkt_start, .pkt_end, .pkt_abort);

	pid_matcher pid_matcher_i (.clk, .rst_n, .byte_valid, .byte_data, .byte_idx,
		.pid_we, .pid_slot, .pid_wdata(wb_wdata), .pid_rslot, .pid_rdata,
		.hit_valid, .hit);

	packet_buffer packet_buffer_i (.clk, .rst_n, .byte_valid, .byte_data,
		.byte_idx, .commit, .rd_word, .rd_data);

	capture_ctrl capture_ctrl_i (.clk, .rst_n, .hit_valid, .hit,
		.pkt_start, .pkt_end, .match_enable, .commit, .matched_count, .capture_valid);

	wb_regs wb_regs_i (.clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata,
		.matched_count, .capture_valid, .pid_rdata, .rd_data, .wb_rdata, .wb_ack,
		.match_enable, .pid_we, .pid_slot, .pid_rslot, .rd_word);

	// a packet cut short never reaches a commit
	assert property (@(posedge clk) disable iff (!rst_n) pkt_abort |=> !commit);

endmodule

`default_nettype wire

// File: bench/tb_ts_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ts_monitor;

	localparam int clk_ns = 40;
	// 12 packets of 188 bytes at up to 3 cycles a byte, 250 register accesses
	localparam int watchdog_ns = (12 * 188 * 3 + 250 * 4) * clk_ns + 100000;

	logic clk;
	logic rst_n;
	logic [7:0] ts_data;
	logic ts_valid;
	logic ts_sync;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [wb_map_pkg::adr_width-1:0] wb_adr;
	logic [31:0] wb_wdata;
	logic [31:0] wb_rdata;
	logic wb_ack;

	int seed = 32'h9a1e;
	int mismatches = 0;
	int failures = 0;

	logic [ts_pkg::pid_width-1:0] model_pid [ts_pkg::num_slots]; // expected PID table
	logic model_en [ts_pkg::num_slots];
	logic model_match;
	logic [31:0] exp_count;
	logic exp_capture;
	logic [7:0] exp_buf [ts_pkg::pkt_bytes]; // last accepted packet

	ts_monitor ts_monitor_i (.clk, .rst_n, .ts_data, .ts_valid, .ts_sync,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata, .wb_ack);

	initial begin
		clk = 1'b0;
		forever #(clk_ns / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired, the tests did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			mismatches++;
			$display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic wait_ack(input logic [8:0] adr);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < 8);
		if (!wb_ack) begin
			failures++;
			$display("no Wishbone ack for address %h within 8 cycles", adr);
		end
	endtask

	task automatic wb_write(input logic [8:0] adr, input logic [31:0] data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= adr;
		wb_wdata <= data;
		wait_ack(adr);
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_read(input logic [8:0] adr, output logic [31:0] data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= adr;
		wait_ack(adr);
		data = wb_rdata; // sampled at negedge, stable
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	function automatic logic [31:0] slot_word(input logic [12:0] pid, input logic en);
		return {15'h2b3c, en, 3'h7, pid}; // junk in the padding
	endfunction

	task automatic set_slot(input int s, input logic [31:0] d);
		wb_write(wb_map_pkg::adr_pid_base + 9'(s * 4), d);
		model_pid[s] = d[12:0];
		model_en[s] = d[16];
	endtask

	task automatic set_match(input logic en);
		wb_write(wb_map_pkg::adr_ctrl, {31'd0, en});
		model_match = en;
	endtask

	function automatic logic accepted(input logic [12:0] pid);
		logic hit;
		hit = 1'b0;
		for (int s = 0; s < ts_pkg::num_slots; s++) begin
			if (model_en[s] && model_pid[s] == pid)
				hit = 1'b1;
		end
		return hit && model_match;
	endfunction

	task automatic send_byte(input logic [7:0] d, input logic s);
		@(posedge clk);
		ts_data <= d;
		ts_valid <= 1'b1;
		ts_sync <= s;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			ts_valid <= 1'b0;
			ts_sync <= 1'b0;
		end
	endtask

	// len below 188 leaves the packet open, so the next sync aborts it
	task automatic send_packet(input logic [12:0] pid, input int len);
		logic [7:0] pkt [ts_pkg::pkt_bytes];
		logic [31:0] r;
		for (int i = 0; i < len; i++) begin
			r = $random(seed);
			case (i)
				0: pkt[i] = ts_pkg::sync_byte;
				1: pkt[i] = {r[7:5], pid[12:8]}; // random header flags
				2: pkt[i] = pid[7:0];
				default: pkt[i] = r[7:0];
			endcase
			if (i > 0 && r[11:8] == 4'd0)
				idle(1 + int'(r[12])); // valid gap
			send_byte(pkt[i], i == 0);
		end
		idle(6); // commit and count settle
		if (len == ts_pkg::pkt_bytes && accepted(pid)) begin
			exp_buf = pkt;
			exp_count = exp_count + 32'd1;
			exp_capture = 1'b1;
		end
	endtask

	task automatic check_regs();
		logic [31:0] got;
		wb_read(wb_map_pkg::adr_count, got);
		check_value("matched count", got, exp_count);
		wb_read(wb_map_pkg::adr_status, got);
		check_value("status", got, {31'd0, exp_capture});
	endtask

	task automatic check_buffer();
		logic [31:0] got;
		for (int w = 0; w < ts_pkg::pkt_words; w++) begin
			wb_read(wb_map_pkg::adr_buf_base + 9'(w * 4), got);
			check_value($sformatf("buffer word %0d", w), got,
				{exp_buf[4*w+3], exp_buf[4*w+2], exp_buf[4*w+1], exp_buf[4*w]});
		end
	endtask

	initial begin
		logic [31:0] d;
		logic [31:0] got;
		logic [31:0] r;
		logic [12:0] pid;
		rst_n <= 1'b0;
		ts_data <= '0;
		ts_valid <= 1'b0;
		ts_sync <= 1'b0;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		wb_adr <= '0;
		wb_wdata <= '0;
		for (int s = 0; s < ts_pkg::num_slots; s++) begin
			model_pid[s] = '0;
			model_en[s] = 1'b0;
		end
		model_match = 1'b0;
		exp_count = '0;
		exp_capture = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		check_regs();

		// slot readback, padding dropped
		for (int s = 0; s < ts_pkg::num_slots; s++) begin
			d = $random(seed);
			set_slot(s, d);
			wb_read(wb_map_pkg::adr_pid_base + 9'(s * 4), got);
			check_value($sformatf("pid slot %0d", s), got, {15'd0, d[16], 3'd0, d[12:0]});
		end

		// matched capture
		set_slot(0, slot_word(13'h0100, 1'b1));
		set_slot(1, slot_word(13'h1abc, 1'b1));
		set_slot(2, slot_word(13'h0021, 1'b1));
		set_slot(3, slot_word(13'h1fff, 1'b0));
		set_match(1'b1);
		send_packet(13'h0100, ts_pkg::pkt_bytes);
		check_regs();
		check_buffer();

		// rejections
		send_packet(13'h0555, ts_pkg::pkt_bytes); // in no slot
		check_regs();
		send_packet(13'h1fff, ts_pkg::pkt_bytes); // slot disabled
		check_regs();
		set_match(1'b0);
		send_packet(13'h1abc, ts_pkg::pkt_bytes);
		check_regs();
		set_match(1'b1);
		check_buffer();

		// abort then a good packet
		send_packet(13'h0021, 100);
		send_packet(13'h1abc, ts_pkg::pkt_bytes);
		check_regs();
		check_buffer();

		// random PIDs over all slots
		set_slot(3, slot_word(13'h1fff, 1'b1));
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			if (i < ts_pkg::num_slots)
				pid = model_pid[i]; // each slot once
			else if (r[2])
				pid = r[15:3];
			else
				pid = model_pid[r[1:0]];
			send_packet(pid, ts_pkg::pkt_bytes);
		end
		check_regs();
		check_buffer();

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hdl/ts_pkg.sv
hdl/wb_map_pkg.sv
hdl/ts_framer.sv
hdl/pid_matcher.sv
hdl/packet_buffer.sv
hdl/capture_ctrl.sv
hdl/wb_regs.sv
hdl/ts_monitor.sv
bench/tb_ts_monitor.sv

// File: run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ts_monitor -f src.f -o sim_tb || exit 1
sim_out="$(./obj_dir/sim_tb)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1
